// ==== flist.f ====
src/sram_adapter_pkg.sv
src/sync_fifo.sv
src/req_check.sv
src/sram_req_ctrl.sv
src/rsp_gen.sv
src/tlul_sram_adapter.sv
verif/sram_model.sv
verif/tb_sram_adapter.sv

// ==== Makefile ====
# Verilator build and run for the TL-UL SRAM adapter testbench

TOP := tb_sram_adapter

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f flist.f --top-module $(TOP) -Mdir obj_dir -o sim

# Pass or fail comes from the log, not the simulator exit code
run: compile
	./obj_dir/sim | tee sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== verif/tb_sram_adapter.sv ====
/*
 * Table-driven testbench for the TL-UL to SRAM adapter.
 * Requests are pipelined under random grant stalls and D back-pressure.
 * Source id carries the table index, responses must come back in table order.
 */
`timescale 1ns/100ps

module tb_sram_adapter import sram_adapter_pkg::*; ();

  localparam int TIMEOUT = 200;

  typedef struct {
    logic [2:0]        op;
    logic [TL_AW-1:0]  addr;
    logic [TL_SZW-1:0] size;
    logic [TL_DBW-1:0] mask;
    logic [TL_DW-1:0]  data;
    logic [1:0]        rerr;
    tl_d_op_e          exp_op;
    logic [TL_DW-1:0]  exp_data;
    logic              exp_err;
  } entry_t;

  logic clk_i, rst_ni;
  logic a_valid_i, a_ready_o, d_valid_o, d_ready_i, d_error_o;
  logic [2:0]         a_opcode_i;
  logic [TL_SZW-1:0]  a_size_i, d_size_o;
  logic [TL_AIW-1:0]  a_source_i, d_source_o;
  logic [TL_AW-1:0]   a_address_i;
  logic [TL_DBW-1:0]  a_mask_i;
  logic [TL_DW-1:0]   a_data_i, d_data_o;
  tl_d_op_e           d_opcode_o;
  logic               sram_req, sram_gnt, sram_we, sram_rvalid, stall;
  logic [SRAM_AW-1:0] sram_addr;
  logic [TL_DW-1:0]   sram_wdata, sram_wmask, sram_rdata;
  logic [1:0]         sram_rerror, inject;

  entry_t      tbl [$];
  logic [31:0] lfsr = 32'h591a_401a;
  int          checks = 0;
  int          mismatches = 0;
  int          failures = 0;

  tlul_sram_adapter tlul_sram_adapter_inst (
    .clk_i, .rst_ni,
    .a_valid_i, .a_ready_o, .a_opcode_i, .a_size_i, .a_source_i,
    .a_address_i, .a_mask_i, .a_data_i,
    .d_valid_o, .d_ready_i, .d_opcode_o, .d_size_o, .d_source_o, .d_data_o, .d_error_o,
    .req_o (sram_req), .gnt_i (sram_gnt), .we_o (sram_we), .addr_o (sram_addr),
    .wdata_o (sram_wdata), .wmask_o (sram_wmask),
    .rvalid_i (sram_rvalid), .rdata_i (sram_rdata), .rerror_i (sram_rerror)
  );

  sram_model sram_model_inst (
    .clk_i, .rst_ni,
    .req_i (sram_req), .gnt_o (sram_gnt), .we_i (sram_we), .addr_i (sram_addr),
    .wdata_i (sram_wdata), .wmask_i (sram_wmask),
    .stall_i (stall), .inject_i (inject),
    .rvalid_o (sram_rvalid), .rdata_o (sram_rdata), .rerror_o (sram_rerror)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Galois LFSR, one step per bit
  function automatic logic take_bit();
    lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
    return lfsr[0];
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      mismatches++;
      $display("error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic add_entry(input logic [2:0] op, input logic [31:0] addr, input logic [1:0] size,
                           input logic [3:0] mask, input logic [31:0] data,
                           input logic [1:0] rerr, input tl_d_op_e exp_op,
                           input logic [31:0] exp_data, input logic exp_err);
    entry_t e;
    e = '{op, addr, size, mask, data, rerr, exp_op, exp_data, exp_err};
    tbl.push_back(e);
  endtask

  // One A beat per entry, next beat follows right after acceptance
  task automatic drive_requests();
    int cycles;
    for (int i = 0; i < tbl.size(); i++) begin
      a_valid_i   <= 1'b1;
      a_opcode_i  <= tbl[i].op;
      a_size_i    <= tbl[i].size;
      a_source_i  <= 8'(i) + 8'h30;
      a_address_i <= tbl[i].addr;
      a_mask_i    <= tbl[i].mask;
      a_data_i    <= tbl[i].data;
      inject      <= tbl[i].rerr;
      cycles = 0;
      do begin
        @(posedge clk_i);
        cycles++;
      end while (!a_ready_o && cycles < TIMEOUT);
      if (!a_ready_o) begin
        failures++;
        $display("timeout: request %0d was never accepted", i);
        break;
      end
    end
    a_valid_i <= 1'b0;
  endtask

  // Checks each D beat in order and drives random back-pressure
  task automatic collect_responses();
    int got, idle;
    logic r0, r1, r2, r3;
    got = 0;
    idle = 0;
    while (got < tbl.size() && idle < TIMEOUT) begin
      @(posedge clk_i);
      if (d_valid_o && d_ready_i) begin
        check_value($sformatf("entry %0d d_source", got), 32'(8'(got) + 8'h30), 32'(d_source_o));
        check_value($sformatf("entry %0d d_opcode", got), 32'(tbl[got].exp_op), 32'(d_opcode_o));
        check_value($sformatf("entry %0d d_size", got), 32'(tbl[got].size), 32'(d_size_o));
        check_value($sformatf("entry %0d d_error", got), 32'(tbl[got].exp_err), 32'(d_error_o));
        check_value($sformatf("entry %0d d_data", got), tbl[got].exp_data, d_data_o);
        got++;
        idle = 0;
      end else begin
        idle++;
      end
      r0 = take_bit();
      r1 = take_bit();
      r2 = take_bit();
      r3 = take_bit();
      // Ready about three cycles in four, grant stalled one in four
      d_ready_i <= r0 | r1;
      stall     <= r2 & r3;
    end
    if (got < tbl.size()) begin
      failures++;
      $display("timeout: only %0d of %0d responses arrived", got, tbl.size());
    end
  endtask

  initial begin
    rst_ni = 1'b0;
    a_valid_i = 1'b0;
    a_opcode_i = '0;
    a_size_i = '0;
    a_source_i = '0;
    a_address_i = '0;
    a_mask_i = '0;
    a_data_i = '0;
    d_ready_i = 1'b0;
    stall = 1'b0;
    inject = '0;

    // Basic put then get, then partial write and partial reads
    add_entry(PutFullData, 32'h10, 2'd2, 4'hf, 32'h1234_5678, 2'b00, AccessAck, 32'h0, 1'b0);
    add_entry(Get, 32'h10, 2'd2, 4'hf, 32'h0, 2'b00, AccessAckData, 32'h1234_5678, 1'b0);
    add_entry(PutPartialData, 32'h10, 2'd2, 4'h5, 32'haabb_ccdd, 2'b00, AccessAck, 32'h0, 1'b0);
    add_entry(Get, 32'h10, 2'd2, 4'hf, 32'h0, 2'b00, AccessAckData, 32'h12bb_56dd, 1'b0);
    add_entry(Get, 32'h12, 2'd1, 4'hc, 32'h0, 2'b00, AccessAckData, 32'h12bb_0000, 1'b0);
    add_entry(Get, 32'h11, 2'd0, 4'h2, 32'h0, 2'b00, AccessAckData, 32'h0000_5600, 1'b0);
    // Illegal requests, none may touch memory
    add_entry(3'h2, 32'h10, 2'd2, 4'hf, 32'h0, 2'b00, AccessAck, DATA_WHEN_ERROR, 1'b1);
    add_entry(PutFullData, 32'h12, 2'd2, 4'hf, 32'h0, 2'b00, AccessAck, DATA_WHEN_ERROR, 1'b1);
    add_entry(Get, 32'h10, 2'd3, 4'hf, 32'h0, 2'b00, AccessAckData, DATA_WHEN_ERROR, 1'b1);
    add_entry(PutFullData, 32'h10, 2'd2, 4'h3, 32'h0, 2'b00, AccessAck, DATA_WHEN_ERROR, 1'b1);
    add_entry(Get, 32'h10, 2'd2, 4'hf, 32'h0, 2'b00, AccessAckData, 32'h12bb_56dd, 1'b0);
    // Uncorrectable read error blanks the data
    add_entry(Get, 32'h10, 2'd2, 4'hf, 32'h0, 2'b10, AccessAckData, DATA_WHEN_ERROR, 1'b1);
    // Untouched word shows the fill pattern of word 0x40
    add_entry(Get, 32'h100, 2'd2, 4'hf, 32'h0, 2'b00, AccessAckData, 32'hb440_5440, 1'b0);
    add_entry(PutFullData, 32'h20, 2'd2, 4'hf, 32'hcafe_f00d, 2'b00, AccessAck, 32'h0, 1'b0);
    add_entry(PutPartialData, 32'h21, 2'd0, 4'h2, 32'h0000_5a00, 2'b00, AccessAck, 32'h0, 1'b0);
    add_entry(Get, 32'h20, 2'd2, 4'hf, 32'h0, 2'b00, AccessAckData, 32'hcafe_5a0d, 1'b0);
    // Correctable error bit is ignored
    add_entry(Get, 32'h20, 2'd2, 4'hf, 32'h0, 2'b01, AccessAckData, 32'hcafe_5a0d, 1'b0);

    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    check_value("idle d_valid", 32'h0, 32'(d_valid_o));
    check_value("idle sram req", 32'h0, 32'(sram_req));

    fork
      drive_requests();
      collect_responses();
    join

    // Nothing may be left over once every response is in
    d_ready_i <= 1'b1;
    repeat (8) begin
      @(posedge clk_i);
      if (d_valid_o) begin
        failures++;
        $display("unexpected extra D response with source %h", d_source_o);
      end
    end

    $display("%0d checks, %0d mismatches, %0d other failures", checks, mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== verif/sram_model.sv ====
/*
 * Behavioral single-ported SRAM, one cycle read latency after grant.
 * Grant drops while stall_i is high; inject_i is returned as rerror with read data.
 * Memory starts filled with a pattern built from the full word address.
 */
`timescale 1ns/100ps

module sram_model import sram_adapter_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_ni,

  // Request side
  input  logic               req_i,
  output logic               gnt_o,
  input  logic               we_i,
  input  logic [SRAM_AW-1:0] addr_i,
  input  logic [TL_DW-1:0]   wdata_i,
  input  logic [TL_DW-1:0]   wmask_i,

  // Test controls
  input  logic               stall_i,
  input  logic [1:0]         inject_i,

  // Read return
  output logic               rvalid_o,
  output logic [TL_DW-1:0]   rdata_o,
  output logic [1:0]         rerror_o
);

  logic [TL_DW-1:0] mem [2**SRAM_AW];

  // Pattern keeps every word distinct
  initial begin
    for (int i = 0; i < 2**SRAM_AW; i++) begin
      mem[i] = {6'h2d, 10'(i), 6'h15, 10'(i)};
    end
  end

  assign gnt_o = req_i && !stall_i;

  // Bit-masked write on a granted write request
  always @(posedge clk_i) begin
    if (req_i && gnt_o && we_i) begin
      mem[addr_i] <= (mem[addr_i] & ~wmask_i) | (wdata_i & wmask_i);
    end
  end

  always @(posedge clk_i) begin
    rdata_o  <= mem[addr_i];
    rerror_o <= inject_i;
  end

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= req_i && gnt_o && !we_i;
    end
  end

endmodule

// ==== src/tlul_sram_adapter.sv ====
/*
 * TL-UL style host port to single-ported SRAM, Get and Put only.
 * Fixed read latency of one cycle after grant, in-order responses.
 */
`timescale 1ns/100ps

module tlul_sram_adapter import sram_adapter_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_ni,

  // Host A channel
  input  logic               a_valid_i,
  output logic               a_ready_o,
  input  logic [2:0]         a_opcode_i,
  input  logic [TL_SZW-1:0]  a_size_i,
  input  logic [TL_AIW-1:0]  a_source_i,
  input  logic [TL_AW-1:0]   a_address_i,
  input  logic [TL_DBW-1:0]  a_mask_i,
  input  logic [TL_DW-1:0]   a_data_i,

  // Host D channel
  output logic               d_valid_o,
  input  logic               d_ready_i,
  output tl_d_op_e           d_opcode_o,
  output logic [TL_SZW-1:0]  d_size_o,
  output logic [TL_AIW-1:0]  d_source_o,
  output logic [TL_DW-1:0]   d_data_o,
  output logic               d_error_o,

  // SRAM port
  output logic               req_o,
  input  logic               gnt_i,
  output logic               we_o,
  output logic [SRAM_AW-1:0] addr_o,
  output logic [TL_DW-1:0]   wdata_o,
  output logic [TL_DW-1:0]   wmask_o,
  input  logic               rvalid_i,
  input  logic [TL_DW-1:0]   rdata_i,
  input  logic [1:0]         rerror_i
);

  // Checked request
  logic               chk_error, chk_is_read, chk_we;
  logic [SRAM_AW-1:0] chk_addr;
  logic [TL_DW-1:0]   chk_wmask, chk_wdata;

  // Request record head
  logic               rec_valid, rec_is_read, rec_error, rec_pop;
  logic [TL_SZW-1:0]  rec_size;
  logic [TL_AIW-1:0]  rec_source;
  logic [TL_DBW-1:0]  rec_mask;

  // Raw opcode bits, illegal codes are flagged by the check
  req_check req_check_inst (
    .a_valid_i   (a_valid_i),
    .a_opcode_i  (tl_a_op_e'(a_opcode_i)),
    .a_size_i    (a_size_i),
    .a_address_i (a_address_i),
    .a_mask_i    (a_mask_i),
    .a_data_i    (a_data_i),
    .error_o     (chk_error),
    .is_read_o   (chk_is_read),
    .we_o        (chk_we),
    .addr_o      (chk_addr),
    .wmask_o     (chk_wmask),
    .wdata_o     (chk_wdata)
  );

  sram_req_ctrl sram_req_ctrl_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .a_valid_i     (a_valid_i),
    .a_size_i      (a_size_i),
    .a_source_i    (a_source_i),
    .a_mask_i      (a_mask_i),
    .a_ready_o     (a_ready_o),
    .error_i       (chk_error),
    .is_read_i     (chk_is_read),
    .we_i          (chk_we),
    .addr_i        (chk_addr),
    .wmask_i       (chk_wmask),
    .wdata_i       (chk_wdata),
    .req_o         (req_o),
    .gnt_i         (gnt_i),
    .we_o          (we_o),
    .addr_o        (addr_o),
    .wdata_o       (wdata_o),
    .wmask_o       (wmask_o),
    .rec_pop_i     (rec_pop),
    .rec_valid_o   (rec_valid),
    .rec_is_read_o (rec_is_read),
    .rec_error_o   (rec_error),
    .rec_size_o    (rec_size),
    .rec_source_o  (rec_source),
    .rec_mask_o    (rec_mask)
  );

  rsp_gen rsp_gen_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .rec_valid_i   (rec_valid),
    .rec_is_read_i (rec_is_read),
    .rec_error_i   (rec_error),
    .rec_size_i    (rec_size),
    .rec_source_i  (rec_source),
    .rec_mask_i    (rec_mask),
    .rec_pop_o     (rec_pop),
    .rvalid_i      (rvalid_i),
    .rdata_i       (rdata_i),
    .rerror_i      (rerror_i),
    .d_valid_o     (d_valid_o),
    .d_ready_i     (d_ready_i),
    .d_opcode_o    (d_opcode_o),
    .d_size_o      (d_size_o),
    .d_source_o    (d_source_o),
    .d_data_o      (d_data_o),
    .d_error_o     (d_error_o)
  );

endmodule

// ==== src/rsp_gen.sv ====
/*
 * Builds in-order D responses from the record head and SRAM read data.
 * Assumes read data one cycle after grant and no more reads than records.
 */
`timescale 1ns/100ps

module rsp_gen import sram_adapter_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,

  // Head of the request FIFO
  input  logic              rec_valid_i,
  input  logic              rec_is_read_i,
  input  logic              rec_error_i,
  input  logic [TL_SZW-1:0] rec_size_i,
  input  logic [TL_AIW-1:0] rec_source_i,
  input  logic [TL_DBW-1:0] rec_mask_i,
  output logic              rec_pop_o,

  // SRAM read return
  input  logic              rvalid_i,
  input  logic [TL_DW-1:0]  rdata_i,
  input  logic [1:0]        rerror_i,

  // D channel
  output logic              d_valid_o,
  input  logic              d_ready_i,
  output tl_d_op_e          d_opcode_o,
  output logic [TL_SZW-1:0] d_size_o,
  output logic [TL_AIW-1:0] d_source_o,
  output logic [TL_DW-1:0]  d_data_o,
  output logic              d_error_o
);

  logic                 rsp_wready, rsp_rvalid, rsp_rready;
  logic [RSP_REC_W-1:0] rsp_wdata, rsp_rdata;
  logic                 rsp_err;
  logic [TL_DW-1:0]     rsp_data, rmask;
  logic                 clean_read;

  // Only the uncorrectable bit matters here
  assign rsp_wdata = {rerror_i[1], rdata_i};

  // Pass-through, so data arriving with an idle D channel leaves at once
  sync_fifo #(
    .Width (RSP_REC_W),
    .Depth (OUTSTANDING),
    .Pass  (1'b1)
  ) rsp_fifo_inst (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wvalid_i (rvalid_i),
    .wready_o (rsp_wready),
    .wdata_i  (rsp_wdata),
    .rvalid_o (rsp_rvalid),
    .rready_i (rsp_rready),
    .rdata_o  (rsp_rdata)
  );

  assign {rsp_err, rsp_data} = rsp_rdata;

  // Mask applied on the way out
  // A clean read at the head owns the oldest response entry,
  // while at push time a pending write record may still sit in front
  always_comb begin
    for (int i = 0; i < TL_DBW; i++) begin
      rmask[8*i +: 8] = {8{rec_mask_i[i]}};
    end
  end

  assign clean_read = rec_valid_i && rec_is_read_i && !rec_error_i;

  // Writes and errors answer at once, clean reads wait for data
  assign d_valid_o  = rec_valid_i && (rec_error_i || !rec_is_read_i || rsp_rvalid);
  assign d_error_o  = d_valid_o && (rec_error_i || (clean_read && rsp_err));
  assign d_opcode_o = rec_is_read_i ? AccessAckData : AccessAck;
  assign d_size_o   = rec_size_i;
  assign d_source_o = rec_source_i;

  always_comb begin
    if (rec_error_i || (clean_read && rsp_err)) begin
      d_data_o = DATA_WHEN_ERROR;
    end else if (clean_read) begin
      d_data_o = rsp_data & rmask;
    end else begin
      d_data_o = '0;
    end
  end

  assign rec_pop_o  = d_valid_o && d_ready_i;
  // Response entry leaves with its own read record only
  assign rsp_rready = rec_pop_o && clean_read;

  assert property (@(posedge clk_i) disable iff (!rst_ni) rvalid_i |-> rec_valid_i)
    else $error("rsp_gen: read data with no pending record");
  assert property (@(posedge clk_i) disable iff (!rst_ni) rvalid_i |-> rsp_wready)
    else $error("rsp_gen: read data while response FIFO full");

endmodule

// ==== src/sram_req_ctrl.sv ====
/*
 * Issues SRAM requests and holds one record per accepted A beat.
 * Error beats skip the SRAM but still get a record for in-order replies.
 */
`timescale 1ns/100ps

module sram_req_ctrl import sram_adapter_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_ni,

  // A channel side
  input  logic               a_valid_i,
  input  logic [TL_SZW-1:0]  a_size_i,
  input  logic [TL_AIW-1:0]  a_source_i,
  input  logic [TL_DBW-1:0]  a_mask_i,
  output logic               a_ready_o,

  // From the request check
  input  logic               error_i,
  input  logic               is_read_i,
  input  logic               we_i,
  input  logic [SRAM_AW-1:0] addr_i,
  input  logic [TL_DW-1:0]   wmask_i,
  input  logic [TL_DW-1:0]   wdata_i,

  // SRAM request
  output logic               req_o,
  input  logic               gnt_i,
  output logic               we_o,
  output logic [SRAM_AW-1:0] addr_o,
  output logic [TL_DW-1:0]   wdata_o,
  output logic [TL_DW-1:0]   wmask_o,

  // Head of the request FIFO
  input  logic               rec_pop_i,
  output logic               rec_valid_o,
  output logic               rec_is_read_o,
  output logic               rec_error_o,
  output logic [TL_SZW-1:0]  rec_size_o,
  output logic [TL_AIW-1:0]  rec_source_o,
  output logic [TL_DBW-1:0]  rec_mask_o
);

  logic                 fifo_wready;
  logic                 push;
  logic [REQ_REC_W-1:0] rec_wdata, rec_rdata;

  // Only clean beats go out, and only while a record slot is free
  // Read data can then always find room in the response FIFO
  assign req_o   = a_valid_i && !error_i && fifo_wready;
  assign we_o    = req_o && we_i;
  assign addr_o  = addr_i;
  assign wdata_o = wdata_i;
  assign wmask_o = wmask_i;

  // Grant accepts a clean beat, errors are taken at once
  assign a_ready_o = fifo_wready && (gnt_i || error_i);
  assign push      = a_valid_i && a_ready_o;

  assign rec_wdata = {is_read_i, error_i, a_size_i, a_source_i, a_mask_i};

  sync_fifo #(
    .Width (REQ_REC_W),
    .Depth (OUTSTANDING),
    .Pass  (1'b0)
  ) req_fifo_inst (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wvalid_i (push),
    .wready_o (fifo_wready),
    .wdata_i  (rec_wdata),
    .rvalid_o (rec_valid_o),
    .rready_i (rec_pop_i),
    .rdata_o  (rec_rdata)
  );

  assign {rec_is_read_o, rec_error_o, rec_size_o, rec_source_o, rec_mask_o} = rec_rdata;

  // An ungranted request stays up with the same address and direction
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req_o && !gnt_i) |=> (req_o && $stable(addr_o) && $stable(we_o)))
    else $error("sram_req_ctrl: SRAM request dropped or changed before grant");

  // Read record is waiting at the head when its data returns
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req_o && gnt_i && !we_o) |=> rec_valid_o)
    else $error("sram_req_ctrl: read issued without a pending record");

endmodule

// ==== src/req_check.sv ====
/*
 * Combinational legality check and SRAM request forming for one A beat.
 * Only bus-wide SRAM words; address bits above SRAM_AW are ignored.
 */
`timescale 1ns/100ps

module req_check import sram_adapter_pkg::*; (
  input  logic              a_valid_i,
  input  tl_a_op_e          a_opcode_i,
  input  logic [TL_SZW-1:0] a_size_i,
  input  logic [TL_AW-1:0]  a_address_i,
  input  logic [TL_DBW-1:0] a_mask_i,
  input  logic [TL_DW-1:0]  a_data_i,
  output logic              error_o,
  output logic              is_read_o,
  output logic              we_o,
  output logic [SRAM_AW-1:0] addr_o,
  output logic [TL_DW-1:0]  wmask_o,
  output logic [TL_DW-1:0]  wdata_o
);

  logic              op_err, size_err, align_err, mask_err, full_err;
  logic              is_put;
  logic [TL_DBW-1:0] span_mask;

  assign is_put    = (a_opcode_i == PutFullData) || (a_opcode_i == PutPartialData);
  assign is_read_o = (a_opcode_i == Get);

  // Anything but the three kept opcodes
  assign op_err   = !(is_put || is_read_o);
  // Size 3 would be a double word
  assign size_err = (a_size_i == 2'd3);

  // Bytes covered by the addressed span
  always_comb begin
    span_mask = '0;
    case (a_size_i)
      2'd0:    span_mask[a_address_i[1:0]] = 1'b1;
      2'd1:    span_mask = a_address_i[1] ? 4'b1100 : 4'b0011;
      default: span_mask = '1;
    endcase
  end

  always_comb begin
    case (a_size_i)
      2'd1:    align_err = a_address_i[0];
      2'd2:    align_err = |a_address_i[1:0];
      default: align_err = 1'b0;
    endcase
  end

  // No byte lanes outside the span
  assign mask_err = |(a_mask_i & ~span_mask);
  // Full puts must write the whole span
  assign full_err = (a_opcode_i == PutFullData) && (a_mask_i != span_mask);

  assign error_o = a_valid_i && (op_err || size_err || align_err || mask_err || full_err);
  assign we_o    = a_valid_i && is_put;

  // Word address, byte offset dropped
  assign addr_o = a_address_i[2 +: SRAM_AW];

  // Byte mask to bit mask, write data cleared where not written
  always_comb begin
    wmask_o = '0;
    wdata_o = '0;
    if (a_valid_i) begin
      for (int i = 0; i < TL_DBW; i++) begin
        wmask_o[8*i +: 8] = {8{a_mask_i[i]}};
        wdata_o[8*i +: 8] = (a_mask_i[i] && is_put) ? a_data_i[8*i +: 8] : 8'h00;
      end
    end
  end

endmodule

// ==== src/sync_fifo.sv ====
/*
 * Synchronous FIFO with count, refuses writes when full.
 * Pass=1 forwards write data to the read side while empty.
 */
`timescale 1ns/100ps

module sync_fifo #(
  parameter int Width = 8,
  parameter int Depth = 2,
  parameter bit Pass  = 1'b0
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             wvalid_i,
  output logic             wready_o,
  input  logic [Width-1:0] wdata_i,
  output logic             rvalid_o,
  input  logic             rready_i,
  output logic [Width-1:0] rdata_o
);

  localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntW = $clog2(Depth + 1);

  logic [Width-1:0] mem [Depth];
  logic [PtrW-1:0]  wr_ptr, rd_ptr;
  logic [CntW-1:0]  count;
  logic             empty, pass_now, do_read, store, take;

  assign empty    = (count == '0);
  assign wready_o = (count != CntW'(Depth));

  // Bypass only while nothing is stored, keeps order intact
  assign pass_now = Pass && empty;
  assign rvalid_o = pass_now ? wvalid_i : !empty;
  assign rdata_o  = pass_now ? wdata_i : mem[rd_ptr];

  assign do_read = rvalid_o && rready_i;
  // A bypassed word consumed in the same cycle never enters the buffer
  assign store   = wvalid_i && wready_o && !(pass_now && do_read);
  assign take    = do_read && !pass_now;

  always_ff @(posedge clk_i) begin
    if (store) begin
      mem[wr_ptr] <= wdata_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (store) begin
        wr_ptr <= (wr_ptr == PtrW'(Depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (take) begin
        rd_ptr <= (rd_ptr == PtrW'(Depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CntW'(store) - CntW'(take);
    end
  end

  // Users must respect full and empty, the FIFO drops nothing silently
  assert property (@(posedge clk_i) disable iff (!rst_ni) wvalid_i |-> wready_o)
    else $error("sync_fifo: write while full");
  assert property (@(posedge clk_i) disable iff (!rst_ni) rready_i |-> rvalid_o)
    else $error("sync_fifo: read while empty");

endmodule

// ==== src/sram_adapter_pkg.sv ====
/*
 * Shared widths, depths and encodings for the TL-UL to SRAM adapter.
 * SRAM word is as wide as the bus word and host addresses above 4 KiB alias.
 */
package sram_adapter_pkg;

  // Host bus widths
  localparam int TL_AW  = 32;
  localparam int TL_DW  = 32;
  localparam int TL_DBW = TL_DW / 8;
  localparam int TL_SZW = 2;
  localparam int TL_AIW = 8;

  // SRAM word address, taken above the byte offset
  localparam int SRAM_AW = 10;

  // Depth of both the request and the response FIFO
  localparam int OUTSTANDING = 2;

  // Blanking value on any error response
  localparam logic [TL_DW-1:0] DATA_WHEN_ERROR = {TL_DW{1'b1}};

  // A channel opcodes, TileLink encoding
  // Other codes are illegal and answered with an error
  typedef enum logic [2:0] {
    PutFullData    = 3'h0,
    PutPartialData = 3'h1,
    Get            = 3'h4
  } tl_a_op_e;

  // D channel opcodes
  typedef enum logic [2:0] {
    AccessAck     = 3'h0,
    AccessAckData = 3'h1
  } tl_d_op_e;

  // Request record kept until its D beat leaves
  // Fields are is-read, error, size, source and byte mask
  localparam int REQ_REC_W = 1 + 1 + TL_SZW + TL_AIW + TL_DBW;

  // Read response record
  // Read data plus the uncorrectable error flag
  localparam int RSP_REC_W = TL_DW + 1;

endpackage
